// ==== Makefile ====
TOP = packet_gate_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f packet_gate_top.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// ==== packet_gate_top.f ====
src/gate_pkg.sv
src/byte_counter.sv
src/frame_fsm.sv
src/lb_driver.sv
src/reg_bank.sv
src/reply_serializer.sv
src/reply_fifo.sv
src/packet_gate_top.sv
tb/packet_gate_tb.sv

// ==== src/byte_counter.sv ====
`timescale 1ns/10ps

module byte_counter
	import gate_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic accept,
	input logic frame_end,
	output logic [2:0] byte_idx,
	output logic word_full,
	output logic nonce_done
);

	// High in the cycle the 8th byte of a word is accepted
	assign word_full = accept && (byte_idx == 3'(WORD_BYTES - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_idx <= '0;
			nonce_done <= 1'b0;
		end else if (accept) begin
			if (frame_end) begin
				// Next frame starts with a fresh nonce
				byte_idx <= '0;
				nonce_done <= 1'b0;
			end else begin
				// Wraps modulo 8 by width
				byte_idx <= byte_idx + 3'd1;
				if (word_full)
					nonce_done <= 1'b1;
			end
		end
	end

endmodule

// ==== src/frame_fsm.sv ====
`timescale 1ns/10ps

module frame_fsm
	import gate_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic accept,
	input rx_beat_t rx_beat,
	input logic [2:0] byte_idx,
	input logic word_full,
	input logic nonce_done,
	output logic echo_we,
	output reply_beat_t echo_beat,
	output logic capture_en,
	output logic word_end,
	output logic frame_last
);

	typedef enum logic [1:0] {
		IDLE,
		NONCE,
		BODY,
		DISCARD
	} state_t;

	state_t state;
	state_t state_nxt;

	// Body bytes go to the bus driver, nonce bytes straight back
	assign capture_en = accept && nonce_done;
	assign word_end = capture_en && word_full && (state == BODY);

	always_comb begin
		state_nxt = state;
		if (accept && rx_beat.last) begin
			// Frame ends; a partial word is dropped through DISCARD
			state_nxt = word_full ? IDLE : DISCARD;
		end else if (accept) begin
			case (state)
				IDLE, DISCARD: state_nxt = NONCE;
				NONCE: state_nxt = word_full ? BODY : NONCE;
				default: state_nxt = BODY;
			endcase
		end else if (state == DISCARD) begin
			state_nxt = IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			echo_we <= 1'b0;
			frame_last <= 1'b0;
		end else begin
			state <= state_nxt;
			echo_we <= accept && !nonce_done;
			// Lines up with the bus strobe one cycle later
			frame_last <= word_end && rx_beat.last;
		end
	end

	// Echo payload, qualified by echo_we
	always_ff @(posedge clk) begin
		echo_beat.data <= rx_beat.data;
		// Last only when the nonce itself closes the frame
		echo_beat.last <= rx_beat.last && (byte_idx == 3'(NONCE_BYTES - 1));
	end

endmodule

// ==== src/gate_pkg.sv ====
package gate_pkg;

	// Frame layout
	localparam int NONCE_BYTES = 8;
	localparam int WORD_BYTES = 8;

	// Local bus widths
	localparam int ADDR_W = 24;
	localparam int DATA_W = 32;

	// Register bank size and index width
	localparam int REG_COUNT = 16;
	localparam int REG_IDX_W = $clog2(REG_COUNT);

	// Reply FIFO sizing
	localparam int REPLY_FIFO_DEPTH = 32;
	localparam int FIFO_PTR_W = $clog2(REPLY_FIFO_DEPTH);
	// Input is throttled below this many free entries
	localparam int RX_HEADROOM = 16;

	// Read flag position inside the control byte
	localparam int CTL_READ_BIT = 4;

	// One byte from the remote host, last marks the frame end
	typedef struct packed {
		logic [7:0] data;
		logic last;
	} rx_beat_t;

	// One local bus request
	typedef struct packed {
		logic rd;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} lb_req_t;

	// One reply byte back to the host
	typedef struct packed {
		logic [7:0] data;
		logic last;
	} reply_beat_t;

endpackage

// ==== src/lb_driver.sv ====
`timescale 1ns/10ps

module lb_driver
	import gate_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic capture_en,
	input rx_beat_t rx_beat,
	input logic word_end,
	output lb_req_t lb_req,
	output logic lb_strobe
);

	logic [8*WORD_BYTES-1:0] word_sr;
	logic [8*WORD_BYTES-1:0] word_nxt;
	lb_req_t req_dec;

	// Word including the byte accepted this cycle
	assign word_nxt = {word_sr[8*WORD_BYTES-9:0], rx_beat.data};

	// Control byte on top, then address, then write data
	always_comb begin
		req_dec.rd = word_nxt[8*(WORD_BYTES-1) + CTL_READ_BIT];
		req_dec.addr = word_nxt[DATA_W +: ADDR_W];
		req_dec.wdata = word_nxt[DATA_W-1:0];
	end

	// Body byte shift register
	always_ff @(posedge clk) begin
		if (capture_en)
			word_sr <= word_nxt;
	end

	// Request is held between strobes so the bus sees it stable
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lb_req <= '0;
			lb_strobe <= 1'b0;
		end else begin
			lb_strobe <= word_end;
			if (word_end)
				lb_req <= req_dec;
		end
	end

endmodule

// ==== src/packet_gate_top.sv ====
`timescale 1ns/10ps

module packet_gate_top
	import gate_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic rx_valid,
	output logic rx_ready,
	input rx_beat_t rx_beat,
	output logic tx_valid,
	input logic tx_ready,
	output reply_beat_t tx_beat
);

	logic accept;
	logic [2:0] byte_idx;
	logic word_full;
	logic nonce_done;
	logic echo_we;
	reply_beat_t echo_beat;
	logic capture_en;
	logic word_end;
	logic frame_last;
	lb_req_t lb_req;
	logic lb_strobe;
	logic [DATA_W-1:0] lb_rdata;
	logic ser_we;
	reply_beat_t ser_beat;
	logic fifo_we;
	reply_beat_t fifo_din;
	logic fifo_empty;
	logic [5:0] fifo_free;
	logic strobe_d;
	logic reply_busy;

	assign accept = rx_valid && rx_ready;

	// Bus strobe delayed to cover the serializer load cycle
	always_ff @(posedge clk) begin
		if (!rst_n)
			strobe_d <= 1'b0;
		else
			strobe_d <= lb_strobe;
	end

	// A reply is on its way into the FIFO
	assign reply_busy = lb_strobe || strobe_d || ser_we;

	// Headroom check, and no new nonce while the last reply still drains
	assign rx_ready = (fifo_free >= 6'(RX_HEADROOM)) && !(reply_busy && !nonce_done);

	// Echo and serializer own the write port at different times
	assign fifo_we = echo_we || ser_we;
	assign fifo_din = echo_we ? echo_beat : ser_beat;

	assign tx_valid = !fifo_empty;

	byte_counter u_byte_counter (
		.clk(clk),
		.rst_n(rst_n),
		.accept(accept),
		.frame_end(rx_beat.last),
		.byte_idx(byte_idx),
		.word_full(word_full),
		.nonce_done(nonce_done)
	);

	frame_fsm u_frame_fsm (
		.clk(clk),
		.rst_n(rst_n),
		.accept(accept),
		.rx_beat(rx_beat),
		.byte_idx(byte_idx),
		.word_full(word_full),
		.nonce_done(nonce_done),
		.echo_we(echo_we),
		.echo_beat(echo_beat),
		.capture_en(capture_en),
		.word_end(word_end),
		.frame_last(frame_last)
	);

	lb_driver u_lb_driver (
		.clk(clk),
		.rst_n(rst_n),
		.capture_en(capture_en),
		.rx_beat(rx_beat),
		.word_end(word_end),
		.lb_req(lb_req),
		.lb_strobe(lb_strobe)
	);

	reg_bank u_reg_bank (
		.clk(clk),
		.rst_n(rst_n),
		.lb_req(lb_req),
		.lb_strobe(lb_strobe),
		.lb_rdata(lb_rdata)
	);

	reply_serializer u_reply_serializer (
		.clk(clk),
		.rst_n(rst_n),
		.lb_strobe(lb_strobe),
		.lb_req(lb_req),
		.frame_last(frame_last),
		.lb_rdata(lb_rdata),
		.fifo_we(ser_we),
		.fifo_beat(ser_beat)
	);

	reply_fifo u_reply_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.we(fifo_we),
		.din(fifo_din),
		.re(tx_valid && tx_ready),
		.dout(tx_beat),
		.empty(fifo_empty),
		.free(fifo_free)
	);

endmodule

// ==== src/reg_bank.sv ====
`timescale 1ns/10ps

module reg_bank
	import gate_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input lb_req_t lb_req,
	input logic lb_strobe,
	output logic [DATA_W-1:0] lb_rdata
);

	logic [DATA_W-1:0] regs [REG_COUNT];
	logic in_range;
	logic [REG_IDX_W-1:0] idx;

	// Upper address bits must be zero to hit the bank
	assign in_range = lb_req.addr < ADDR_W'(REG_COUNT);
	assign idx = lb_req.addr[REG_IDX_W-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (lb_strobe && !lb_req.rd && in_range) begin
			regs[idx] <= lb_req.wdata;
		end
	end

	// Combinational read, out of range reads zero
	assign lb_rdata = in_range ? regs[idx] : '0;

endmodule

// ==== src/reply_fifo.sv ====
`timescale 1ns/10ps

module reply_fifo
	import gate_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic we,
	input reply_beat_t din,
	input logic re,
	output reply_beat_t dout,
	output logic empty,
	output logic [5:0] free
);

	reply_beat_t mem [REPLY_FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0] count;
	logic do_we;
	logic do_re;

	// Writes to a full FIFO and reads from an empty one are ignored
	assign do_we = we && (count != (FIFO_PTR_W+1)'(REPLY_FIFO_DEPTH));
	assign do_re = re && (count != '0);

	always_ff @(posedge clk) begin
		if (do_we)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Pointers wrap by width
			if (do_we)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_re)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_we, do_re})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Fall-through head
	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign free = 6'(REPLY_FIFO_DEPTH) - 6'(count);

endmodule

// ==== src/reply_serializer.sv ====
`timescale 1ns/10ps

module reply_serializer
	import gate_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic lb_strobe,
	input lb_req_t lb_req,
	input logic frame_last,
	input logic [DATA_W-1:0] lb_rdata,
	output logic fifo_we,
	output reply_beat_t fifo_beat
);

	logic load_pend;
	logic last_pend;
	logic last_q;
	logic [3:0] cnt;
	logic [8*WORD_BYTES-1:0] sr;
	logic [7:0] ctl_byte;

	// Control byte rebuilt from the read flag
	always_comb begin
		ctl_byte = '0;
		ctl_byte[CTL_READ_BIT] = lb_req.rd;
	end

	// Bytes still to write, most significant first
	assign fifo_we = (cnt != '0);
	assign fifo_beat.data = sr[8*WORD_BYTES-1 -: 8];
	assign fifo_beat.last = last_q && (cnt == 4'd1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			load_pend <= 1'b0;
			last_pend <= 1'b0;
			last_q <= 1'b0;
			cnt <= '0;
		end else begin
			// Wait one cycle so the bank shows the written value
			load_pend <= lb_strobe;
			if (lb_strobe)
				last_pend <= frame_last;
			if (load_pend) begin
				// A new reply may start on the last byte of the previous one
				cnt <= 4'(WORD_BYTES);
				last_q <= last_pend;
			end else if (fifo_we) begin
				cnt <= cnt - 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_pend)
			sr <= {ctl_byte, lb_req.addr, lb_rdata};
		else if (fifo_we)
			sr <= {sr[8*WORD_BYTES-9:0], 8'h00};
	end

endmodule

// ==== tb/packet_gate_tb.sv ====
`timescale 1ns/10ps

module packet_gate_tb
	import gate_pkg::*;
();

	logic clk;
	logic rst_n;
	logic rx_valid;
	logic rx_ready;
	rx_beat_t rx_beat;
	logic tx_valid;
	logic tx_ready;
	reply_beat_t tx_beat;

	// Bytes to send, replies expected and replies seen
	rx_beat_t frame_q[$];
	reply_beat_t exp_q[$];
	reply_beat_t got_q[$];
	// Register contents as the host expects them
	logic [DATA_W-1:0] model [REG_COUNT];
	int mismatches;
	int failures;

	packet_gate_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.rx_beat(rx_beat),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx_beat(tx_beat)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		rx_valid = 1'b0;
		tx_ready = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		// Bank comes out of reset all zero
		for (int i = 0; i < REG_COUNT; i++)
			model[i] = '0;
	endtask

	task automatic clear_queues();
		frame_q.delete();
		exp_q.delete();
		got_q.delete();
	endtask

	// Random nonce, echoed back unchanged
	task automatic new_frame();
		rx_beat_t b;
		reply_beat_t r;
		for (int i = 0; i < NONCE_BYTES; i++) begin
			b.data = 8'($urandom);
			b.last = 1'b0;
			r.data = b.data;
			r.last = 1'b0;
			frame_q.push_back(b);
			exp_q.push_back(r);
		end
	endtask

	// One bus transaction and its expected 8-byte answer
	task automatic add_txn(input logic rd, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata);
		logic [7:0] ctl;
		logic [DATA_W-1:0] rdata;
		logic [8*WORD_BYTES-1:0] word;
		logic [8*WORD_BYTES-1:0] reply;
		rx_beat_t b;
		reply_beat_t r;
		ctl = '0;
		ctl[CTL_READ_BIT] = rd;
		// Only the 16 registers hold data
		if (!rd && addr < ADDR_W'(REG_COUNT))
			model[addr[REG_IDX_W-1:0]] = wdata;
		rdata = (addr < ADDR_W'(REG_COUNT)) ? model[addr[REG_IDX_W-1:0]] : '0;
		word = {ctl, addr, wdata};
		reply = {ctl, addr, rdata};
		for (int i = 0; i < WORD_BYTES; i++) begin
			b.data = word[8*(WORD_BYTES-1-i) +: 8];
			b.last = 1'b0;
			r.data = reply[8*(WORD_BYTES-1-i) +: 8];
			r.last = 1'b0;
			frame_q.push_back(b);
			exp_q.push_back(r);
		end
	endtask

	// Frame end on the last byte sent and on the last byte expected back
	task automatic close_frame();
		rx_beat_t b;
		reply_beat_t r;
		b = frame_q.pop_back();
		b.last = 1'b1;
		frame_q.push_back(b);
		r = exp_q.pop_back();
		r.last = 1'b1;
		exp_q.push_back(r);
	endtask

	task automatic send_frame();
		int idx;
		int idle;
		idx = 0;
		idle = 0;
		while (idx < frame_q.size() && idle < 2000) begin
			@(negedge clk);
			rx_valid = 1'b1;
			rx_beat = frame_q[idx];
			// Taken on the coming rising edge
			if (rx_ready) begin
				idx++;
				idle = 0;
			end else begin
				idle++;
			end
		end
		@(negedge clk);
		rx_valid = 1'b0;
		if (idx < frame_q.size()) begin
			$display("send_frame: rx_ready stuck low, %0d of %0d bytes sent", idx, frame_q.size());
			failures++;
		end
	endtask

	task automatic collect_reply(input int n, input bit random_stall);
		int idle;
		idle = 0;
		got_q.delete();
		while (got_q.size() < n && idle < 2000) begin
			@(negedge clk);
			tx_ready = random_stall ? 1'($urandom_range(0, 1)) : 1'b1;
			if (tx_valid && tx_ready) begin
				got_q.push_back(tx_beat);
				idle = 0;
			end else begin
				idle++;
			end
		end
		// Let the final byte go, then hold the rest in the FIFO
		@(negedge clk);
		tx_ready = 1'b0;
		if (got_q.size() < n) begin
			$display("collect_reply: reply stopped after %0d of %0d bytes", got_q.size(), n);
			failures++;
		end
	endtask

	task automatic wait_for_rx_stall();
		int idle;
		idle = 0;
		while (rx_ready && idle < 2000) begin
			@(negedge clk);
			idle++;
		end
		if (rx_ready) begin
			$display("wait_for_rx_stall: rx_ready never dropped with tx_ready low");
			failures++;
		end
	endtask

	task automatic check_beat(input string name, input reply_beat_t exp, input reply_beat_t act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %02h last %0b, actual %02h last %0b",
				name, exp.data, exp.last, act.data, act.last);
			mismatches++;
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
			mismatches++;
		end
	endtask

	task automatic check_reply(input string name);
		if (got_q.size() != exp_q.size()) begin
			$display("%s: got %0d reply bytes instead of %0d", name, got_q.size(), exp_q.size());
			failures++;
		end
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
			check_beat($sformatf("%s byte %0d", name, i), exp_q[i], got_q[i]);
	endtask

	// Read data field of the reply word starting at base
	function automatic logic [DATA_W-1:0] word_from_reply(input int base);
		logic [DATA_W-1:0] w;
		w = '0;
		if (got_q.size() >= base + WORD_BYTES) begin
			for (int i = 4; i < WORD_BYTES; i++)
				w = {w[DATA_W-9:0], got_q[base+i].data};
		end
		return w;
	endfunction

	task automatic run_frames(input string name);
		fork
			send_frame();
			collect_reply(exp_q.size(), 1'b0);
		join
		check_reply(name);
	endtask

	task automatic test_nonce_only();
		clear_queues();
		new_frame();
		close_frame();
		run_frames("nonce_only");
	endtask

	task automatic test_write_read();
		logic [ADDR_W-1:0] addr;
		addr = ADDR_W'($urandom_range(0, REG_COUNT - 1));
		clear_queues();
		new_frame();
		add_txn(1'b0, addr, $urandom);
		// Write data of a read is ignored
		add_txn(1'b1, addr, $urandom);
		close_frame();
		run_frames("write_read");
	endtask

	task automatic test_reg_access();
		logic [ADDR_W-1:0] addrs [6];
		logic [DATA_W-1:0] want [6];
		addrs = '{24'd1, 24'd6, 24'd11, 24'd15, ADDR_W'(REG_COUNT), 24'h800006};
		clear_queues();
		new_frame();
		for (int i = 0; i < 4; i++) begin
			want[i] = $urandom;
			add_txn(1'b0, addrs[i], want[i]);
		end
		// Out of range writes leave the bank alone
		// Last one aliases register 6 in its low bits
		want[4] = '0;
		want[5] = '0;
		add_txn(1'b0, addrs[4], $urandom);
		add_txn(1'b0, addrs[5], $urandom);
		close_frame();
		run_frames("reg_write");
		// One read frame per address
		for (int i = 0; i < 6; i++) begin
			clear_queues();
			new_frame();
			add_txn(1'b1, addrs[i], $urandom);
			close_frame();
			run_frames($sformatf("reg_read %0d", i));
			check_word($sformatf("reg_read addr %06h", addrs[i]), want[i],
				word_from_reply(NONCE_BYTES));
		end
	endtask

	task automatic test_backpressure();
		clear_queues();
		new_frame();
		for (int i = 0; i < 12; i++)
			add_txn(1'($urandom_range(0, 1)), ADDR_W'($urandom_range(0, REG_COUNT - 1)), $urandom);
		close_frame();
		// tx_ready stays low until the FIFO throttles the input
		fork
			send_frame();
			begin
				wait_for_rx_stall();
				collect_reply(exp_q.size(), 1'b1);
			end
		join
		check_reply("backpressure");
	endtask

	task automatic test_back_to_back();
		logic [DATA_W-1:0] val;
		val = $urandom;
		clear_queues();
		new_frame();
		add_txn(1'b0, 24'd9, val);
		close_frame();
		// Second frame queued right behind the first
		new_frame();
		add_txn(1'b1, 24'd9, $urandom);
		close_frame();
		run_frames("back_to_back");
		check_word("back_to_back read", val, word_from_reply(2*NONCE_BYTES + WORD_BYTES));
	endtask

	task automatic test_reset_mid_frame();
		rx_beat_t b;
		clear_queues();
		new_frame();
		// Three bytes of a word that never completes
		for (int i = 0; i < 3; i++) begin
			b.data = 8'($urandom);
			b.last = 1'b0;
			frame_q.push_back(b);
		end
		send_frame();
		apply_reset();
		// Echoed nonce must be gone with the reset
		repeat (20) begin
			@(negedge clk);
			if (tx_valid) begin
				$display("reset_mid_frame: tx_valid high after reset");
				failures++;
			end
			if (!rx_ready) begin
				$display("reset_mid_frame: rx_ready low with an empty FIFO");
				failures++;
			end
		end
		clear_queues();
		new_frame();
		close_frame();
		run_frames("after_reset");
	endtask

	initial begin
		rst_n = 1'b0;
		rx_valid = 1'b0;
		rx_beat = '0;
		tx_ready = 1'b0;
		mismatches = 0;
		failures = 0;
		void'($urandom(91));
		apply_reset();
		test_nonce_only();
		test_write_read();
		test_reg_access();
		test_backpressure();
		test_back_to_back();
		test_reset_mid_frame();
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
